// File: all.f
src/timer_pkg.sv
src/timer_regs.sv
src/timer_clock_sel.sv
src/timer_counter.sv
src/compare_unit.sv
src/timer_a.sv
test/tb_timer_a.sv

// File: src/compare_unit.sv
/*
 * One compare channel. Detects when the counter is about to reach the
 * channel's TACCRn, drives its output pin through the eight output modes
 * and raises the channel's compare flag. Instantiated once per channel.
 */
`timescale 1ns/100ps
`default_nettype none

module compare_unit (
  input  logic               mclk,
  input  logic               puc_rst,
  input  logic               tar_clk,
  input  timer_pkg::word_t   tar,
  input  timer_pkg::word_t   tar_nxt,
  input  timer_pkg::word_t   ccr,
  input  timer_pkg::cctl_t   cctl,
  input  timer_pkg::mc_t     mc,
  input  logic               equ0,        // Channel 0 match
  input  logic               clr_pulse,
  output logic               equ,
  output logic               ccifg_set,
  output logic               ta_out
);
  import timer_pkg::*;

  logic out_nxt;

  // Match on entering TACCRn, not while sitting on it
  assign equ = (tar_nxt == ccr) & (tar != ccr);

  always_comb begin
    case (cctl.outmod)
      OM_OUT:     out_nxt = cctl.out;
      OM_SET:     out_nxt = equ ? 1'b1 : ta_out;
      OM_TOG_RST: out_nxt = equ ? ~ta_out : (equ0 ? 1'b0 : ta_out);
      OM_SET_RST: out_nxt = equ ? 1'b1 : (equ0 ? 1'b0 : ta_out);
      OM_TOG:     out_nxt = equ ? ~ta_out : ta_out;
      OM_RST:     out_nxt = equ ? 1'b0 : ta_out;
      OM_TOG_SET: out_nxt = equ ? ~ta_out : (equ0 ? 1'b1 : ta_out);
      default:    out_nxt = equ ? 1'b0 : (equ0 ? 1'b1 : ta_out);  // Reset/set
    endcase
  end

  // Output flop, only moves on a counter step
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      ta_out <= 1'b0;
    else if ((cctl.outmod == OM_SET) & clr_pulse)
      ta_out <= 1'b0;                     // TACLR restarts set mode
    else if (tar_clk)
      ta_out <= out_nxt;
  end

  assign ccifg_set = tar_clk & (mc != MC_STOP) & equ;

endmodule

`default_nettype wire

// File: src/timer_a.sv
/*
 * Top level of the compare-only Timer A. Connects the register block,
 * the clock select, the TAR counter and one compare unit per channel.
 * NUM_CH and BASE_ADDR are set here and handed to the register block.
 */
`timescale 1ns/100ps
`default_nettype none

module timer_a #(
  parameter int          NUM_CH    = 3,
  parameter logic [14:0] BASE_ADDR = 15'h0100
) (
  input  logic                 mclk,
  input  logic                 puc_rst,
  input  timer_pkg::per_req_t  per_req,
  input  logic                 taclk,
  input  logic                 aclk_en,
  input  logic                 smclk_en,
  input  logic                 dbg_freeze,
  input  logic                 irq_ta0_acc,
  output timer_pkg::word_t     per_dout,
  output logic                 irq_ta0,
  output logic                 irq_ta1,
  output logic [NUM_CH-1:0]    ta_out
);
  import timer_pkg::*;

  tactl_t                   ctl;
  logic                     clr_pulse;
  logic                     tar_wr;
  word_t                    wdata;
  word_t  [NUM_CH-1:0]      ccr;
  cctl_t  [NUM_CH-1:0]      cctl;
  logic                     tar_clk;      // Counter step
  logic                     cnt_step;     // Step not held by debug freeze
  word_t                    tar;
  word_t                    tar_nxt;
  logic                     taifg_set;
  logic   [NUM_CH-1:0]      ccifg_set;
  logic   [NUM_CH-1:0]      equ;

  assign cnt_step = tar_clk & ~dbg_freeze;

  timer_regs #(.NUM_CH(NUM_CH), .BASE_ADDR(BASE_ADDR)) u_regs (
    .mclk(mclk), .puc_rst(puc_rst), .per_req(per_req), .tar(tar),
    .taifg_set(taifg_set), .ccifg_set(ccifg_set), .irq_ta0_acc(irq_ta0_acc),
    .per_dout(per_dout), .ctl(ctl), .clr_pulse(clr_pulse), .tar_wr(tar_wr),
    .wdata(wdata), .ccr(ccr), .cctl(cctl), .irq_ta0(irq_ta0), .irq_ta1(irq_ta1)
  );

  timer_clock_sel u_clk_sel (
    .mclk(mclk), .puc_rst(puc_rst), .taclk(taclk), .aclk_en(aclk_en),
    .smclk_en(smclk_en), .ctl(ctl), .clr_pulse(clr_pulse), .tar_clk(tar_clk)
  );

  timer_counter u_counter (
    .mclk(mclk), .puc_rst(puc_rst), .tar_clk(tar_clk), .dbg_freeze(dbg_freeze),
    .ctl(ctl), .clr_pulse(clr_pulse), .tar_wr(tar_wr), .wdata(wdata),
    .ccr0(ccr[0]), .tar(tar), .tar_nxt(tar_nxt), .taifg_set(taifg_set)
  );

  // Channel 0 match also feeds the second half of modes 2, 3, 6, 7
  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    compare_unit u_cmp (
      .mclk(mclk), .puc_rst(puc_rst), .tar_clk(cnt_step), .tar(tar),
      .tar_nxt(tar_nxt), .ccr(ccr[g]), .cctl(cctl[g]), .mc(ctl.mc),
      .equ0(equ[0]), .clr_pulse(clr_pulse), .equ(equ[g]),
      .ccifg_set(ccifg_set[g]), .ta_out(ta_out[g])
    );
  end

endmodule

`default_nettype wire

// File: src/timer_clock_sel.sv
/*
 * Timer clock select. Synchronizes TACLK, detects both of its edges,
 * picks one of four sources and divides it by 1, 2, 4 or 8 to form the
 * one-cycle counter step pulse tar_clk.
 */
`timescale 1ns/100ps
`default_nettype none

module timer_clock_sel (
  input  logic               mclk,
  input  logic               puc_rst,
  input  logic               taclk,
  input  logic               aclk_en,
  input  logic               smclk_en,
  input  timer_pkg::tactl_t  ctl,
  input  logic               clr_pulse,
  output logic               tar_clk
);
  import timer_pkg::*;

  logic [1:0] taclk_sync;                 // Two-flop synchronizer
  logic       taclk_dly;                  // Edge detect flop
  logic       taclk_rise;
  logic       taclk_fall;
  logic       sel_clk;
  logic       div_hit;
  logic [2:0] clk_div;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      taclk_sync <= 2'b00;
      taclk_dly  <= 1'b0;
    end else begin
      taclk_sync <= {taclk_sync[0], taclk};
      taclk_dly  <= taclk_sync[1];
    end
  end

  assign taclk_rise = taclk_sync[1] & ~taclk_dly;
  assign taclk_fall = ~taclk_sync[1] & taclk_dly;  // Fills the INCLK slot

  always_comb begin
    case (ctl.tassel)
      2'd0:    sel_clk = taclk_rise;
      2'd1:    sel_clk = aclk_en;
      2'd2:    sel_clk = smclk_en;
      default: sel_clk = taclk_fall;
    endcase
    case (ctl.id)
      2'd0:    div_hit = 1'b1;
      2'd1:    div_hit = clk_div[0];
      2'd2:    div_hit = &clk_div[1:0];
      default: div_hit = &clk_div;
    endcase
  end

  assign tar_clk = sel_clk & div_hit;

  // Prescaler counts source pulses, holds in stop mode
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      clk_div <= 3'd0;
    else if (tar_clk | clr_pulse)
      clk_div <= 3'd0;
    else if ((ctl.mc != MC_STOP) & sel_clk)
      clk_div <= clk_div + 3'd1;
  end

endmodule

`default_nettype wire

// File: src/timer_counter.sv
/*
 * TAR counter. Computes the next count for stop, up, continuous and
 * up/down modes, keeps the up/down direction, and flags TAIFG on
 * overflow. Bus writes and TACLR take precedence over a count step.
 */
`timescale 1ns/100ps
`default_nettype none

module timer_counter (
  input  logic               mclk,
  input  logic               puc_rst,
  input  logic               tar_clk,
  input  logic               dbg_freeze,
  input  timer_pkg::tactl_t  ctl,
  input  logic               clr_pulse,
  input  logic               tar_wr,
  input  timer_pkg::word_t   wdata,
  input  timer_pkg::word_t   ccr0,
  output timer_pkg::word_t   tar,
  output timer_pkg::word_t   tar_nxt,
  output logic               taifg_set
);
  import timer_pkg::*;

  logic  mode_up;
  logic  mode_cont;
  logic  mode_ud;
  logic  tar_clr;
  logic  tar_inc;
  logic  tar_dec;
  logic  tar_dir;                         // 1 while counting down
  logic  tar_step;                        // Step that TAR actually takes
  word_t tar_add;

  assign mode_up   = (ctl.mc == MC_UP);
  assign mode_cont = (ctl.mc == MC_CONT);
  assign mode_ud   = (ctl.mc == MC_UPDOWN);
  assign tar_step  = tar_clk & ~dbg_freeze;

  // --------------------------------------------------------------------------
  // Next count value
  // --------------------------------------------------------------------------
  assign tar_clr = (mode_up & (tar >= ccr0))             // Wrap at TACCR0
                 | (mode_ud & (ccr0 == 16'h0000));        // Degenerate up/down
  assign tar_inc = mode_up | mode_cont | (mode_ud & ~tar_dec);
  assign tar_dec = tar_dir | (mode_ud & (tar >= ccr0));   // Turn at the top
  assign tar_add = tar_inc ? 16'h0001 : (tar_dec ? 16'hFFFF : 16'h0000);
  assign tar_nxt = tar_clr ? 16'h0000 : tar + tar_add;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      tar_dir <= 1'b0;
    else if (clr_pulse)
      tar_dir <= 1'b0;
    else if (mode_ud) begin
      if (tar_step & (tar == 16'h0001))
        tar_dir <= 1'b0;                  // Bottom reached, go up
      else if (tar >= ccr0)
        tar_dir <= 1'b1;
    end else
      tar_dir <= 1'b0;
  end

  // --------------------------------------------------------------------------
  // TAR register
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst)
      tar <= 16'h0000;
    else if (tar_wr)
      tar <= wdata;
    else if (clr_pulse)
      tar <= 16'h0000;
    else if (tar_step)                    // Frozen while debugging
      tar <= tar_nxt;
  end

  assign taifg_set = tar_step & ((mode_up & (tar == ccr0))
                               | (mode_cont & (tar == 16'hFFFF))
                               | (mode_ud & tar_dec & ~tar_clr & (tar_nxt == 16'h0000)));

endmodule

`default_nettype wire

// File: src/timer_pkg.sv
/*
 * Shared types and constants for the compare-only Timer A peripheral.
 * Every block imports this package for widths, register offsets,
 * register field layouts and mode encodings.
 */
`default_nettype none

package timer_pkg;

  typedef logic [15:0] word_t;            // Register / data word
  typedef logic [13:0] per_addr_t;        // Peripheral word address
  typedef logic [6:0]  reg_off_t;         // Byte offset in block

  // Register byte offsets, channel n adds 2n
  localparam reg_off_t TACTL_OFF   = 7'h60;
  localparam reg_off_t TAR_OFF     = 7'h70;
  localparam reg_off_t TACCTL0_OFF = 7'h62;
  localparam reg_off_t TACCR0_OFF  = 7'h72;
  localparam reg_off_t TAIV_OFF    = 7'h2E;

  // Vector codes, channel n reports 2n
  localparam logic [3:0] TAIV_NONE = 4'h0;
  localparam logic [3:0] TAIV_OVF  = 4'hA;

  typedef enum logic [1:0] {
    MC_STOP   = 2'b00,
    MC_UP     = 2'b01,                    // Up to TACCR0
    MC_CONT   = 2'b10,                    // Free running
    MC_UPDOWN = 2'b11
  } mc_t;

  typedef enum logic [2:0] {
    OM_OUT, OM_SET, OM_TOG_RST, OM_SET_RST, OM_TOG, OM_RST, OM_TOG_SET, OM_RST_SET
  } outmod_t;

  typedef struct packed {
    per_addr_t  addr;
    word_t      din;
    logic       en;                       // Access strobe
    logic [1:0] we;                       // Byte write enables
  } per_req_t;

  typedef struct packed {
    logic [1:0] tassel;                   // Clock source
    logic [1:0] id;                       // Input divider
    mc_t        mc;
    logic       unused;
    logic       clr;                      // Never stored, reads 0
    logic       ie;
    logic       ifg;                      // TAIFG
  } tactl_t;

  typedef struct packed {
    logic [7:0] rsv_hi;
    outmod_t    outmod;
    logic       ccie;
    logic       rsv3;
    logic       out;                      // Level for OM_OUT
    logic       rsv1;
    logic       ccifg;
  } cctl_t;

endpackage

`default_nettype wire

// File: src/timer_regs.sv
/*
 * Register block of the timer. Decodes the peripheral bus, holds TACTL,
 * the per-channel TACCTLn and TACCRn, merges flag sets and clears, and
 * computes TAIV and both interrupt lines. Read data is combinational.
 */
`timescale 1ns/100ps
`default_nettype none

module timer_regs #(
  parameter int          NUM_CH    = 3,
  parameter logic [14:0] BASE_ADDR = 15'h0100
) (
  input  logic                              mclk,
  input  logic                              puc_rst,
  input  timer_pkg::per_req_t               per_req,
  input  timer_pkg::word_t                  tar,
  input  logic                              taifg_set,
  input  logic              [NUM_CH-1:0]    ccifg_set,
  input  logic                              irq_ta0_acc,
  output timer_pkg::word_t                  per_dout,
  output timer_pkg::tactl_t                 ctl,
  output logic                              clr_pulse,
  output logic                              tar_wr,
  output timer_pkg::word_t                  wdata,
  output timer_pkg::word_t  [NUM_CH-1:0]    ccr,
  output timer_pkg::cctl_t  [NUM_CH-1:0]    cctl,
  output logic                              irq_ta0,
  output logic                              irq_ta1
);
  import timer_pkg::*;

  localparam logic [9:0]  TACTL_WMASK = 10'h3F3;
  localparam logic [15:0] CCTL_WMASK  = 16'h00F5;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  logic              reg_sel;
  logic              reg_write;
  logic              reg_read;
  reg_off_t          reg_off;
  logic              tactl_wr;
  logic              taiv_acc;
  logic [NUM_CH-1:0] cctl_sel;
  logic [NUM_CH-1:0] ccr_sel;
  logic [NUM_CH-1:0] ccifg_clr;
  logic [3:0]        taiv;
  logic              taifg_clr;
  tactl_t            tactl_din;
  word_t             rd_data;

  assign reg_sel   = per_req.en & (per_req.addr[13:6] == BASE_ADDR[14:7]);
  assign reg_off   = {per_req.addr[5:0], 1'b0};          // Word aligned
  assign reg_write = reg_sel & (|per_req.we);
  assign reg_read  = reg_sel & ~(|per_req.we);

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      cctl_sel[i] = (reg_off == reg_off_t'(TACCTL0_OFF + 2 * i));
      ccr_sel[i]  = (reg_off == reg_off_t'(TACCR0_OFF + 2 * i));
    end
  end

  assign tactl_wr  = reg_write & (reg_off == TACTL_OFF);
  assign tactl_din = tactl_t'(per_req.din[9:0]);
  assign clr_pulse = tactl_wr & tactl_din.clr;           // Self clearing
  assign tar_wr    = reg_write & (reg_off == TAR_OFF);
  assign wdata     = per_req.din;
  assign taiv_acc  = reg_sel & (reg_off == TAIV_OFF);    // Read or write

  // --------------------------------------------------------------------------
  // Interrupt vector
  // --------------------------------------------------------------------------
  always_comb begin
    taiv = TAIV_NONE;
    if (ctl.ifg & ctl.ie)
      taiv = TAIV_OVF;
    for (int i = NUM_CH - 1; i >= 1; i--) begin           // Lowest channel wins
      if (cctl[i].ccifg & cctl[i].ccie)
        taiv = 4'(2 * i);
    end
  end

  always_comb begin
    ccifg_clr[0] = irq_ta0_acc;                         // CCIFG0 by ack only
    for (int i = 1; i < NUM_CH; i++)
      ccifg_clr[i] = taiv_acc & (taiv == 4'(2 * i));
  end

  assign taifg_clr = taiv_acc & (taiv == TAIV_OVF);

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ctl  <= '0;
      ccr  <= '0;
      cctl <= '0;
    end else begin
      if (tactl_wr)
        ctl <= tactl_t'(per_req.din[9:0] & TACTL_WMASK);
      // Flag merge overrides the written bit
      ctl.ifg <= ((tactl_wr ? per_req.din[0] : ctl.ifg) | taifg_set) & ~taifg_clr;
      for (int i = 0; i < NUM_CH; i++) begin
        if (reg_write & ccr_sel[i])
          ccr[i] <= per_req.din;
        if (reg_write & cctl_sel[i])
          cctl[i] <= cctl_t'(per_req.din & CCTL_WMASK);
        cctl[i].ccifg <= (((reg_write & cctl_sel[i]) ? per_req.din[0] : cctl[i].ccifg)
                          | ccifg_set[i]) & ~ccifg_clr[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read mux and interrupt lines
  // --------------------------------------------------------------------------
  always_comb begin
    rd_data = '0;
    if (reg_off == TACTL_OFF)
      rd_data |= {6'h00, ctl};
    if (reg_off == TAR_OFF)
      rd_data |= tar;
    if (reg_off == TAIV_OFF)
      rd_data |= {12'h000, taiv};
    for (int i = 0; i < NUM_CH; i++) begin
      if (cctl_sel[i])
        rd_data |= cctl[i];
      if (ccr_sel[i])
        rd_data |= ccr[i];
    end
    per_dout = reg_read ? rd_data : '0;                 // Idle bus reads 0
  end

  assign irq_ta0 = cctl[0].ccifg & cctl[0].ccie;

  always_comb begin
    irq_ta1 = ctl.ifg & ctl.ie;
    for (int i = 1; i < NUM_CH; i++)
      irq_ta1 |= cctl[i].ccifg & cctl[i].ccie;
  end

endmodule

`default_nettype wire

// File: test/tb_timer_a.sv
/*
 * Testbench for the compare-only Timer A. Drives the peripheral bus and
 * clock enables on the falling edge, runs register, counting, divider
 * and output/interrupt tests against a reference model, and reports.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_timer_a;
  import timer_pkg::*;

  typedef struct packed {
    logic [15:0] tar;
    logic        dir;                     // Counting down
    logic        ifg;                     // TAIFG raised by this step
  } step_t;

  logic        mclk;
  logic        puc_rst;
  per_req_t    per_req;
  logic        taclk;
  logic        aclk_en;
  logic        smclk_en;
  logic        dbg_freeze;
  logic        irq_ta0_acc;
  word_t       per_dout;
  logic        irq_ta0;
  logic        irq_ta1;
  logic [2:0]  ta_out;

  logic [31:0] lfsr;
  int          cyc;                       // Rising edges so far
  int          rd_cyc;                    // Edge count at last read sample
  int          mark;                      // Edge count at model start
  int          errors;
  int          checks;
  int          test_errs;
  int          test_checks;
  mc_t         m_mode;
  word_t       m_tar;
  word_t       m_ccr0;
  logic        m_dir;
  logic        m_ifg;
  int          m_steps;
  word_t       rd;
  word_t       w_ctl;
  word_t       w_cctl [3];
  word_t       w_ccr  [3];
  word_t       ccr_v  [3];
  outmod_t     om     [3];
  word_t       p;
  int          k;
  int          pulses;
  step_t       st;
  logic        e0;
  logic [2:0]  exp_out;

  timer_a #(.NUM_CH(3), .BASE_ADDR(15'h0100)) i_timer_a (
    .mclk(mclk), .puc_rst(puc_rst), .per_req(per_req), .taclk(taclk),
    .aclk_en(aclk_en), .smclk_en(smclk_en), .dbg_freeze(dbg_freeze),
    .irq_ta0_acc(irq_ta0_acc), .per_dout(per_dout), .irq_ta0(irq_ta0),
    .irq_ta1(irq_ta1), .ta_out(ta_out)
  );

  initial begin
    mclk = 1'b0;
    forever #2 mclk = ~mclk;              // 4 ns period
  end

  always @(posedge mclk) cyc <= cyc + 1;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
  endfunction

  function logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);             // One step per bit
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic per_addr_t addr_of(input reg_off_t off);
    return per_addr_t'((16'h0100 + 16'(off)) >> 1);  // Byte to word address
  endfunction

  function automatic reg_off_t cctl_off(input int n);
    return reg_off_t'(TACCTL0_OFF + 2 * n);
  endfunction

  function automatic reg_off_t ccr_off(input int n);
    return reg_off_t'(TACCR0_OFF + 2 * n);
  endfunction

  // Expected counter step
  function automatic step_t model_step(input mc_t mode, input word_t tar,
                                       input word_t ccr0, input logic dir);
    step_t s;
    s.tar = tar;
    s.dir = 1'b0;
    s.ifg = 1'b0;
    case (mode)
      MC_UP: begin
        s.ifg = (tar == ccr0);
        s.tar = (tar >= ccr0) ? 16'h0000 : tar + 16'd1;
      end
      MC_CONT: begin
        s.ifg = (tar == 16'hFFFF);
        s.tar = tar + 16'd1;              // Wraps to 0
      end
      MC_UPDOWN: begin
        if (ccr0 == 16'h0000)
          s.tar = 16'h0000;
        else if (dir || (tar >= ccr0)) begin
          s.tar = tar - 16'd1;
          s.dir = (s.tar != 16'h0000);
          s.ifg = (s.tar == 16'h0000);    // Only at the bottom
        end else
          s.tar = tar + 16'd1;
      end
      default: s.dir = dir;               // Stop holds
    endcase
    return s;
  endfunction

  // Expected output bit for one step
  function automatic logic out_expect(input outmod_t mode, input logic cur,
                                      input logic out_bit, input logic equ,
                                      input logic equ0);
    case (mode)
      OM_OUT:     return out_bit;
      OM_SET:     return equ | cur;
      OM_TOG_RST: return equ ? ~cur : (cur & ~equ0);
      OM_SET_RST: return equ | (cur & ~equ0);
      OM_TOG:     return cur ^ equ;
      OM_RST:     return cur & ~equ;
      OM_TOG_SET: return equ ? ~cur : (cur | equ0);
      default:    return ~equ & (cur | equ0);
    endcase
  endfunction

  task automatic idle(input int n);
    repeat (n) @(negedge mclk);
  endtask

  task automatic do_reset();
    @(negedge mclk);
    puc_rst = 1'b1;
    idle(3);
    puc_rst = 1'b0;
  endtask

  task automatic bus_write(input reg_off_t off, input word_t data);
    @(negedge mclk);
    per_req.addr = addr_of(off);
    per_req.din  = data;
    per_req.en   = 1'b1;
    per_req.we   = 2'b11;
    @(negedge mclk);
    per_req = '0;
  endtask

  task automatic bus_read(input per_addr_t addr, output word_t data);
    @(negedge mclk);
    per_req      = '0;
    per_req.addr = addr;
    per_req.en   = 1'b1;
    #1;
    data   = per_dout;                    // Combinational read data
    rd_cyc = cyc;
    @(negedge mclk);
    per_req = '0;
  endtask

  task automatic check(input string name, input word_t exp, input word_t act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errors++;
      test_errs++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, test_checks, test_errs);
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic start_model(input mc_t mode, input word_t tar0, input word_t ccr0);
    m_mode  = mode;
    m_tar   = tar0;
    m_ccr0  = ccr0;
    m_dir   = 1'b0;
    m_ifg   = 1'b0;
    m_steps = 0;
    mark    = cyc;                        // Steps start after this edge
  endtask

  // Catch the model up with the steps seen at the last read
  task automatic sync_model();
    step_t s;
    while (m_steps < rd_cyc - mark) begin
      s = model_step(m_mode, m_tar, m_ccr0, m_dir);
      m_tar = s.tar;
      m_dir = s.dir;
      m_ifg |= s.ifg;
      m_steps++;
    end
  endtask

  task automatic wait_irq_high(input logic line1, input string name);
    int n;
    n = 0;
    while (((line1 ? irq_ta1 : irq_ta0) !== 1'b1) && (n < 50)) begin
      @(negedge mclk);
      n++;
    end
    if ((line1 ? irq_ta1 : irq_ta0) !== 1'b1) begin
      errors++;
      test_errs++;
      $display("Timeout in %s: interrupt line never went high", name);
    end
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial begin
    puc_rst     = 1'b1;
    per_req     = '0;
    taclk       = 1'b0;
    aclk_en     = 1'b0;
    smclk_en    = 1'b0;
    dbg_freeze  = 1'b0;
    irq_ta0_acc = 1'b0;
    lfsr        = 32'h35177c4e;
    errors      = 0;
    checks      = 0;
    test_errs   = 0;
    test_checks = 0;

    // Register access, no clock source active
    do_reset();
    w_ctl = rand_bits(16);
    bus_write(TACTL_OFF, w_ctl);
    for (int n = 0; n < 3; n++) begin
      w_cctl[n] = rand_bits(16);
      bus_write(cctl_off(n), w_cctl[n]);
      w_ccr[n] = rand_bits(16);
      bus_write(ccr_off(n), w_ccr[n]);
    end
    bus_read(addr_of(TACTL_OFF), rd);
    check("tactl", w_ctl & 16'h03F3, rd);  // clr never stored
    for (int n = 0; n < 3; n++) begin
      bus_read(addr_of(cctl_off(n)), rd);
      check("tacctl", w_cctl[n] & 16'h00F5, rd);
      bus_read(addr_of(ccr_off(n)), rd);
      check("taccr", w_ccr[n], rd);
    end
    bus_read(addr_of(7'h00), rd);
    check("unmapped", 16'h0000, rd);
    bus_read(14'h0000, rd);                // Outside the block
    check("outside", 16'h0000, rd);
    end_test("register access");

    // Up mode from SMCLK, one step per cycle
    do_reset();
    smclk_en = 1'b1;
    p = 16'd8 + rand_bits(4);
    bus_write(ccr_off(0), p);
    bus_write(TACTL_OFF, 16'h0210);
    start_model(MC_UP, 16'h0000, p);
    idle(24 + rand_bits(5));
    bus_read(addr_of(TAR_OFF), rd);
    sync_model();
    check("up tar", m_tar, rd);
    bus_read(addr_of(TACTL_OFF), rd);
    sync_model();
    check("up taifg", 16'(m_ifg), {15'h0000, rd[0]});

    // Continuous mode, preload near the top
    do_reset();
    k = rand_bits(3);
    bus_write(TAR_OFF, 16'hFFFF - 16'(k));
    bus_write(TACTL_OFF, 16'h0222);        // SMCLK, continuous, TAIE
    start_model(MC_CONT, 16'hFFFF - 16'(k), 16'h0000);
    idle(k + 2);
    bus_read(addr_of(TAR_OFF), rd);
    sync_model();
    check("cont tar", m_tar, rd);
    for (int n = 0; n < 2; n++) begin
      bus_read(addr_of(TAIV_OFF), rd);
      sync_model();
      check("cont taiv", m_ifg ? 16'h000A : 16'h0000, rd);
      m_ifg = 1'b0;                       // Access clears the vector
    end
    end_test("up and continuous");

    // Up/down triangle
    do_reset();
    p = 16'd4 + rand_bits(5);
    bus_write(ccr_off(0), p);
    bus_write(TACTL_OFF, 16'h0230);
    start_model(MC_UPDOWN, 16'h0000, p);
    for (int i = 0; i < p + 4; i++) begin
      bus_read(addr_of(TAR_OFF), rd);
      sync_model();
      check("updown tar", m_tar, rd);
      bus_read(addr_of(TACTL_OFF), rd);
      sync_model();
      check("updown taifg", 16'(m_ifg), {15'h0000, rd[0]});
    end
    end_test("up/down");

    // Divide by 8 on random SMCLK enables
    do_reset();
    smclk_en = 1'b0;
    pulses = 0;
    bus_write(TACTL_OFF, 16'h02E4);        // SMCLK, /8, continuous, clr
    for (int i = 0; i < 200; i++) begin
      smclk_en = rand_bits(1);
      pulses += smclk_en;
      @(negedge mclk);
    end
    smclk_en = 1'b0;
    bus_read(addr_of(TAR_OFF), rd);
    check("div8 steps", 16'(pulses / 8), rd);

    // Slow TACLK, one step per rising edge
    do_reset();
    k = 2 + rand_bits(3);
    bus_write(TACTL_OFF, 16'h0020);
    for (int i = 0; i < k; i++) begin
      taclk = 1'b1;
      idle(4);
      taclk = 1'b0;
      idle(4);
    end
    idle(4);                              // Synchronizer latency
    bus_read(addr_of(TAR_OFF), rd);
    check("taclk steps", 16'(k), rd);
    end_test("divider and source");

    // Output modes and interrupts in up mode
    do_reset();
    smclk_en = 1'b1;
    p = 16'd12 + rand_bits(3);
    ccr_v[0] = p;
    ccr_v[1] = 16'd2 + rand_bits(3);
    ccr_v[2] = 16'd3 + rand_bits(3);
    om[0] = OM_OUT;
    om[1] = OM_TOG;
    om[2] = OM_SET_RST;
    for (int n = 0; n < 3; n++) begin
      bus_write(ccr_off(n), ccr_v[n]);
      bus_write(cctl_off(n), 16'({om[n], 5'b10100}));   // Mode, CCIE and OUT
    end
    bus_write(TACTL_OFF, 16'h0210);
    m_tar = 16'h0000;
    exp_out = 3'b000;
    for (int j = 0; j < 3 * (p + 1); j++) begin
      check("ta_out", 16'(exp_out), 16'(ta_out));
      st = model_step(MC_UP, m_tar, p, 1'b0);
      e0 = (st.tar == p) && (m_tar != p);
      for (int n = 0; n < 3; n++)
        exp_out[n] = out_expect(om[n], exp_out[n], 1'b1,
                                (st.tar == ccr_v[n]) && (m_tar != ccr_v[n]), e0);
      m_tar = st.tar;
      @(negedge mclk);
    end
    wait_irq_high(1'b1, "irq_ta1");
    bus_write(TACTL_OFF, 16'h0200);        // Stop counting
    bus_read(addr_of(TAIV_OFF), rd);
    check("taiv ch1", 16'h0002, rd);
    bus_read(addr_of(TAIV_OFF), rd);
    check("taiv ch2", 16'h0004, rd);
    bus_read(addr_of(TAIV_OFF), rd);
    check("taiv none", 16'h0000, rd);
    check("irq_ta1 low", 16'h0000, 16'(irq_ta1));
    wait_irq_high(1'b0, "irq_ta0");
    @(negedge mclk);
    irq_ta0_acc = 1'b1;
    @(negedge mclk);
    irq_ta0_acc = 1'b0;
    check("irq_ta0 ack", 16'h0000, 16'(irq_ta0));
    end_test("outputs and interrupts");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
